/* rtl/cache_bank.sv */
`timescale 1ns/100ps

module cache_bank #(
  parameter int                 NUM_WAYS = cache_pkg::NUM_WAYS_DEFAULT,
  parameter cache_pkg::ret_id_t BANK_ID  = 4'd0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  cache_pkg::cache_req_t req_data,
  output logic                  ack,
  output cache_pkg::cache_rsp_t rsp,
  output logic                  fill_req,
  output cache_pkg::mem_req_t   fill_msg,
  input  logic                  fill_ack,
  input  cache_pkg::line_t      fill_data,
  output logic                  wb_req,
  output cache_pkg::mem_req_t   wb_msg,
  input  logic                  wb_ack
);

  cache_pkg::index_t index;
  cache_pkg::tag_t   lookup_tag;

  // Registered array read data
  cache_pkg::tag_t [NUM_WAYS-1:0]  tags;
  logic [NUM_WAYS-1:0]             valids;
  logic [NUM_WAYS-1:0]             dirtys;
  cache_pkg::age_t [NUM_WAYS-1:0]  ages;
  cache_pkg::line_t [NUM_WAYS-1:0] lines;

  // Lookup results
  logic             hit;
  cache_pkg::way_t  hit_way;
  cache_pkg::way_t  victim_way;
  logic             victim_dirty;
  cache_pkg::tag_t  victim_tag;
  cache_pkg::line_t hit_line;
  cache_pkg::line_t merged_line;

  // Array update controls
  cache_pkg::line_t wr_data_line;
  cache_pkg::mask_t wr_data_mask;
  logic             tag_wr_en;
  logic             data_wr_en;
  cache_pkg::way_t  wr_way;
  logic             wr_dirty;
  logic             touch_en;
  cache_pkg::way_t  touch_way;

  cache_miss_ctrl #(
    .BANK_ID(BANK_ID)
  ) u_ctrl (
    .clk(clk),
    .rst_n(rst_n),
    .req(req),
    .req_data(req_data),
    .ack(ack),
    .rsp(rsp),
    .fill_req(fill_req),
    .fill_msg(fill_msg),
    .fill_ack(fill_ack),
    .fill_data(fill_data),
    .wb_req(wb_req),
    .wb_msg(wb_msg),
    .wb_ack(wb_ack),
    .index(index),
    .lookup_tag(lookup_tag),
    .wr_data_line(wr_data_line),
    .wr_data_mask(wr_data_mask),
    .hit(hit),
    .hit_way(hit_way),
    .victim_way(victim_way),
    .victim_dirty(victim_dirty),
    .victim_tag(victim_tag),
    .hit_line(hit_line),
    .merged_line(merged_line),
    .tag_wr_en(tag_wr_en),
    .data_wr_en(data_wr_en),
    .wr_way(wr_way),
    .wr_dirty(wr_dirty),
    .touch_en(touch_en),
    .touch_way(touch_way)
  );

  cache_tag_store #(
    .NUM_WAYS(NUM_WAYS)
  ) u_tags (
    .clk(clk),
    .rst_n(rst_n),
    .rd_index(index),
    .tags(tags),
    .valids(valids),
    .dirtys(dirtys),
    .ages(ages),
    .wr_en(tag_wr_en),
    .wr_way(wr_way),
    .wr_tag(lookup_tag),
    .wr_dirty(wr_dirty),
    .touch_en(touch_en),
    .touch_way(touch_way)
  );

  cache_data_store #(
    .NUM_WAYS(NUM_WAYS)
  ) u_data (
    .clk(clk),
    .rd_index(index),
    .lines(lines),
    .wr_en(data_wr_en),
    .wr_index(index),
    .wr_way(wr_way),
    .wr_line(wr_data_line),
    .wr_mask(wr_data_mask)
  );

  cache_lookup #(
    .NUM_WAYS(NUM_WAYS)
  ) u_lookup (
    .tag(lookup_tag),
    .tags(tags),
    .valids(valids),
    .dirtys(dirtys),
    .ages(ages),
    .lines(lines),
    .wr_line(wr_data_line),
    .wr_mask(wr_data_mask),
    .hit(hit),
    .hit_way(hit_way),
    .victim_way(victim_way),
    .victim_dirty(victim_dirty),
    .victim_tag(victim_tag),
    .hit_line(hit_line),
    .merged_line(merged_line)
  );

endmodule

/* rtl/cache_data_store.sv */
`timescale 1ns/100ps

module cache_data_store #(
  parameter int NUM_WAYS = 4
) (
  input  logic                             clk,
  input  cache_pkg::index_t                rd_index,
  output cache_pkg::line_t [NUM_WAYS-1:0]  lines,
  input  logic                             wr_en,
  input  cache_pkg::index_t                wr_index,
  input  cache_pkg::way_t                  wr_way,
  input  cache_pkg::line_t                 wr_line,
  input  cache_pkg::mask_t                 wr_mask
);

  cache_pkg::line_t line_mem [cache_pkg::NUM_SETS][NUM_WAYS];

  // Only bytes with a set mask bit change; an install passes a full mask
  always_ff @(posedge clk) begin
    if (wr_en) begin
      line_mem[wr_index][wr_way] <= cache_pkg::merge_line(line_mem[wr_index][wr_way],
                                                          wr_line, wr_mask);
    end
  end

  // All ways of the set are read together
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      lines[w] <= line_mem[rd_index][w];
    end
  end

endmodule

/* rtl/cache_lookup.sv */
`timescale 1ns/100ps

module cache_lookup #(
  parameter int NUM_WAYS = 4
) (
  input  cache_pkg::tag_t                  tag,
  input  cache_pkg::tag_t [NUM_WAYS-1:0]   tags,
  input  logic [NUM_WAYS-1:0]              valids,
  input  logic [NUM_WAYS-1:0]              dirtys,
  input  cache_pkg::age_t [NUM_WAYS-1:0]   ages,
  input  cache_pkg::line_t [NUM_WAYS-1:0]  lines,
  input  cache_pkg::line_t                 wr_line,
  input  cache_pkg::mask_t                 wr_mask,
  output logic                             hit,
  output cache_pkg::way_t                  hit_way,
  output cache_pkg::way_t                  victim_way,
  output logic                             victim_dirty,
  output cache_pkg::tag_t                  victim_tag,
  output cache_pkg::line_t                 hit_line,
  output cache_pkg::line_t                 merged_line
);

  logic            found_free;
  cache_pkg::age_t oldest_age;
  cache_pkg::way_t sel_way;

  // Tag compare against valid ways
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (valids[w] && tags[w] == tag) begin
        hit = 1'b1;
        hit_way = cache_pkg::way_t'(w);
      end
    end
  end

  // Victim: first invalid way, else the oldest one
  always_comb begin
    found_free = 1'b0;
    oldest_age = '0;
    victim_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found_free) begin
        if (!valids[w]) begin
          found_free = 1'b1;
          victim_way = cache_pkg::way_t'(w);
        end else if (ages[w] >= oldest_age) begin
          oldest_age = ages[w];
          victim_way = cache_pkg::way_t'(w);
        end
      end
    end
  end

  assign victim_dirty = valids[victim_way] && dirtys[victim_way];
  assign victim_tag = tags[victim_way];

  // On a miss this is the victim line, which the writeback needs
  assign sel_way = hit ? hit_way : victim_way;
  assign hit_line = lines[sel_way];

  assign merged_line = cache_pkg::merge_line(hit_line, wr_line, wr_mask);

endmodule

/* rtl/cache_miss_ctrl.sv */
`timescale 1ns/100ps

module cache_miss_ctrl #(
  parameter cache_pkg::ret_id_t BANK_ID = '0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  cache_pkg::cache_req_t req_data,
  output logic                  ack,
  output cache_pkg::cache_rsp_t rsp,
  output logic                  fill_req,
  output cache_pkg::mem_req_t   fill_msg,
  input  logic                  fill_ack,
  input  cache_pkg::line_t      fill_data,
  output logic                  wb_req,
  output cache_pkg::mem_req_t   wb_msg,
  input  logic                  wb_ack,
  output cache_pkg::index_t     index,
  output cache_pkg::tag_t       lookup_tag,
  output cache_pkg::line_t      wr_data_line,
  output cache_pkg::mask_t      wr_data_mask,
  input  logic                  hit,
  input  cache_pkg::way_t       hit_way,
  input  cache_pkg::way_t       victim_way,
  input  logic                  victim_dirty,
  input  cache_pkg::tag_t       victim_tag,
  input  cache_pkg::line_t      hit_line,
  input  cache_pkg::line_t      merged_line,
  output logic                  tag_wr_en,
  output logic                  data_wr_en,
  output cache_pkg::way_t       wr_way,
  output logic                  wr_dirty,
  output logic                  touch_en,
  output cache_pkg::way_t       touch_way
);

  cache_pkg::miss_state_t state;
  cache_pkg::cache_req_t  req_q;
  logic                   rd_wait;

  cache_pkg::way_t   victim_q;
  cache_pkg::paddr_t wb_addr;
  cache_pkg::line_t  wb_line;
  cache_pkg::line_t  fill_line;
  cache_pkg::line_t  rsp_line;
  cache_pkg::paddr_t line_addr;

  logic uncached;
  logic eval;
  logic bypass;
  logic fill_done;
  logic install_go;

  assign uncached = req_q.addr[14];
  assign line_addr = {req_q.addr[14:4], 4'b0000};
  assign index = req_q.addr[5:4];
  assign lookup_tag = req_q.addr[13:6];

  // Array data is valid once the read cycle has passed
  assign eval = (state == cache_pkg::st_lookup) && !rd_wait && !uncached;
  assign bypass = (state == cache_pkg::st_lookup) && uncached;
  assign fill_done = (state == cache_pkg::st_fill) && fill_ack;
  assign install_go = (state == cache_pkg::st_install) && !fill_ack && !uncached;

  // Write hit merges into the way; install puts the clean fill line in the victim way
  assign tag_wr_en = (eval && hit && req_q.write) || install_go;
  assign data_wr_en = tag_wr_en;
  assign wr_way = install_go ? victim_q : hit_way;
  assign wr_dirty = eval;
  assign wr_data_line = install_go ? fill_line : req_q.data;
  assign wr_data_mask = install_go ? '1 : req_q.mask;
  assign touch_en = eval && hit;
  assign touch_way = hit_way;

  always_comb begin
    fill_msg.write = 1'b0;
    fill_msg.addr = line_addr;
    fill_msg.data = '0;
    fill_msg.ret_id = BANK_ID;
    fill_msg.size = cache_pkg::size_t'(cache_pkg::LINE_BYTES);
  end

  always_comb begin
    wb_msg.write = 1'b1;
    wb_msg.addr = wb_addr;
    wb_msg.data = wb_line;
    wb_msg.ret_id = BANK_ID;
    wb_msg.size = cache_pkg::size_t'(cache_pkg::LINE_BYTES);
  end

  assign rsp.data = rsp_line;
  assign rsp.uncached = uncached;

  always_ff @(posedge clk) begin
    if (state == cache_pkg::st_idle && req) begin
      req_q <= req_data;
      rsp_line <= req_data.data;
    end
    if (eval && hit) begin
      rsp_line <= req_q.write ? merged_line : hit_line;
    end
    if (eval && !hit) begin
      victim_q <= victim_way;
      wb_addr <= {1'b0, victim_tag, req_q.addr[5:4], 4'b0000};
      wb_line <= hit_line;
    end
    if (bypass) begin
      wb_addr <= line_addr;
      wb_line <= req_q.data;
    end
    if (fill_done) begin
      fill_line <= fill_data;
      if (uncached) begin
        rsp_line <= fill_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= cache_pkg::st_idle;
      rd_wait <= 1'b0;
      ack <= 1'b0;
      fill_req <= 1'b0;
      wb_req <= 1'b0;
    end else begin
      case (state)
        cache_pkg::st_idle: begin
          if (req) begin
            rd_wait <= 1'b1;
            state <= cache_pkg::st_lookup;
          end
        end
        cache_pkg::st_lookup: begin
          if (uncached) begin
            if (req_q.write) begin
              wb_req <= 1'b1;
              state <= cache_pkg::st_writeback;
            end else begin
              fill_req <= 1'b1;
              state <= cache_pkg::st_fill;
            end
          end else if (rd_wait) begin
            rd_wait <= 1'b0;
          end else if (hit) begin
            state <= cache_pkg::st_respond;
          end else if (victim_dirty) begin
            wb_req <= 1'b1;
            state <= cache_pkg::st_writeback;
          end else begin
            fill_req <= 1'b1;
            state <= cache_pkg::st_fill;
          end
        end
        cache_pkg::st_writeback: begin
          // Wait for both halves of the extract handshake
          if (wb_req) begin
            if (wb_ack) begin
              wb_req <= 1'b0;
            end
          end else if (!wb_ack) begin
            if (uncached) begin
              state <= cache_pkg::st_respond;
            end else begin
              fill_req <= 1'b1;
              state <= cache_pkg::st_fill;
            end
          end
        end
        cache_pkg::st_fill: begin
          if (fill_ack) begin
            fill_req <= 1'b0;
            state <= cache_pkg::st_install;
          end
        end
        cache_pkg::st_install: begin
          // Re-read the set so the hit path finishes the request
          if (!fill_ack) begin
            if (uncached) begin
              state <= cache_pkg::st_respond;
            end else begin
              rd_wait <= 1'b1;
              state <= cache_pkg::st_lookup;
            end
          end
        end
        cache_pkg::st_respond: begin
          ack <= 1'b1;
          state <= cache_pkg::st_release;
        end
        cache_pkg::st_release: begin
          if (!req) begin
            ack <= 1'b0;
            state <= cache_pkg::st_idle;
          end
        end
        default: begin
          state <= cache_pkg::st_idle;
        end
      endcase
    end
  end

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

  parameter int NUM_WAYS_DEFAULT = 4;
  parameter int NUM_SETS = 4;
  parameter int LINE_BYTES = 16;

  // Address layout: bit 14 uncacheable, 13..6 tag, 5..4 index, 3..0 offset
  typedef logic [14:0] paddr_t;
  typedef logic [7:0] tag_t;
  typedef logic [1:0] index_t;
  typedef logic [127:0] line_t;
  typedef logic [15:0] mask_t;
  typedef logic [1:0] way_t;

  // 0 is the most recently used way of a set
  typedef logic [1:0] age_t;

  typedef logic [3:0] ret_id_t;
  typedef logic [15:0] size_t;

  typedef struct packed {
    logic   write;
    paddr_t addr;
    line_t  data;
    mask_t  mask;
  } cache_req_t;

  typedef struct packed {
    line_t data;
    logic  uncached;
  } cache_rsp_t;

  // Memory side message, used on both the fill and the extract port
  typedef struct packed {
    logic    write;
    paddr_t  addr;
    line_t   data;
    ret_id_t ret_id;
    size_t   size;
  } mem_req_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_respond,
    st_writeback,
    st_fill,
    st_install,
    st_release
  } miss_state_t;

  // Byte-wise merge of new data over an old line
  function automatic line_t merge_line(line_t old_line, line_t new_line, mask_t mask);
    line_t result;
    result = old_line;
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (mask[b]) begin
        result[b*8 +: 8] = new_line[b*8 +: 8];
      end
    end
    return result;
  endfunction

endpackage

/* rtl/cache_tag_store.sv */
`timescale 1ns/100ps

module cache_tag_store #(
  parameter int NUM_WAYS = 4
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  cache_pkg::index_t                rd_index,
  output cache_pkg::tag_t [NUM_WAYS-1:0]   tags,
  output logic [NUM_WAYS-1:0]              valids,
  output logic [NUM_WAYS-1:0]              dirtys,
  output cache_pkg::age_t [NUM_WAYS-1:0]   ages,
  input  logic                             wr_en,
  input  cache_pkg::way_t                  wr_way,
  input  cache_pkg::tag_t                  wr_tag,
  input  logic                             wr_dirty,
  input  logic                             touch_en,
  input  cache_pkg::way_t                  touch_way
);

  cache_pkg::tag_t tag_mem [cache_pkg::NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0] valid_mem [cache_pkg::NUM_SETS];
  logic [NUM_WAYS-1:0] dirty_mem [cache_pkg::NUM_SETS];
  cache_pkg::age_t age_mem [cache_pkg::NUM_SETS][NUM_WAYS];

  // Age of the way being touched, before the update
  cache_pkg::age_t touch_age;

  assign touch_age = age_mem[rd_index][touch_way];

  // Tag of the installed or written way
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[rd_index][wr_way] <= wr_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
        valid_mem[s] <= '0;
        dirty_mem[s] <= '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
          age_mem[s][w] <= cache_pkg::age_t'(w);
        end
      end
    end else begin
      if (wr_en) begin
        valid_mem[rd_index][wr_way] <= 1'b1;
        dirty_mem[rd_index][wr_way] <= wr_dirty;
      end
      // Touched way becomes youngest, ways younger than it shift up by one
      if (touch_en) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (cache_pkg::way_t'(w) == touch_way) begin
            age_mem[rd_index][w] <= '0;
          end else if (age_mem[rd_index][w] < touch_age) begin
            age_mem[rd_index][w] <= age_mem[rd_index][w] + cache_pkg::age_t'(1);
          end
        end
      end
    end
  end

  // Registered read, one cycle after the index
  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      tags[w] <= tag_mem[rd_index][w];
      ages[w] <= age_mem[rd_index][w];
    end
    valids <= valid_mem[rd_index];
    dirtys <= dirty_mem[rd_index];
  end

endmodule

/* sources.f */
rtl/cache_pkg.sv
rtl/cache_tag_store.sv
rtl/cache_data_store.sv
rtl/cache_lookup.sv
rtl/cache_miss_ctrl.sv
rtl/cache_bank.sv
tests/cache_bank_checker.sv
tests/cache_bank_tb.sv

/* tests/cache_bank_checker.sv */
`timescale 1ns/100ps

module cache_bank_checker (
  input logic clk,
  input logic rst_n,
  input logic req,
  input logic ack,
  input logic fill_req,
  input logic fill_ack,
  input logic wb_req,
  input logic wb_ack
);

  // Response only while a request is pending
  ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a pending req");

  fill_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    fill_req && !fill_ack |=> fill_req)
    else $error("fill_req dropped before fill_ack");

  wb_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req && !wb_ack |=> wb_req)
    else $error("wb_req dropped before wb_ack");

  // One memory port at a time
  one_mem_req: assert property (@(posedge clk) disable iff (!rst_n)
    !(fill_req && wb_req))
    else $error("fill_req and wb_req high together");

  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !ack && !fill_req && !wb_req)
    else $error("control output high during reset");

endmodule

bind cache_bank cache_bank_checker u_checker (
  .clk(clk),
  .rst_n(rst_n),
  .req(req),
  .ack(ack),
  .fill_req(fill_req),
  .fill_ack(fill_ack),
  .wb_req(wb_req),
  .wb_ack(wb_ack)
);

/* tests/cache_bank_stimulus.txt */
// Columns: op addr data mask expect flags, all hex
// op 0 read, 1 write, 2 expect_wb (addr and expect are the extract port address and line)
// flags: 1 hit with 3 cycle ack, 2 uncached response, 4 exactly one fill request

// Cold read fills set 1
0 0010 0 0 797877767574737271706f6e6d6c6b6a 4

// Masked write hit, then two read hits of the merged line
1 0010 00112233445566778899aabbccddeeff 00ff 79787776757473728899aabbccddeeff 1
0 0010 0 0 79787776757473728899aabbccddeeff 1
0 0018 0 0 79787776757473728899aabbccddeeff 1

// Three more tags fill the remaining ways of set 1
0 0050 0 0 b9b8b7b6b5b4b3b2b1b0afaeadacabaa 4
0 0090 0 0 f9f8f7f6f5f4f3f2f1f0efeeedecebea 4
0 00d0 0 0 393837363534333231302f2e2d2c2b2a 4

// Fifth tag evicts the dirty least recently used way
0 0110 0 0 787976777475727370716e6f6c6d6a6b 4
2 0010 0 0 79787776757473728899aabbccddeeff 0

// Evicted line returns from memory with the written bytes
0 0010 0 0 79787776757473728899aabbccddeeff 4

// Uncacheable write, then reads that go to memory each time
1 4020 deadbeef0123456789abcdeffedcba98 ffff deadbeef0123456789abcdeffedcba98 2
2 4020 0 0 deadbeef0123456789abcdeffedcba98 0
0 4020 0 0 deadbeef0123456789abcdeffedcba98 6
0 4020 0 0 deadbeef0123456789abcdeffedcba98 6
0 4030 0 0 d9d8d7d6d5d4d3d2d1d0cfcecdcccbca 6

// Write miss in set 2 fills, installs and merges
1 0220 a1a2a3a4000000000000000000000000 f000 a1a2a3a48786818083827d7c7f7e7978 4
0 0220 0 0 a1a2a3a48786818083827d7c7f7e7978 1

// Lines still resident in set 1
0 0110 0 0 787976777475727370716e6f6c6d6a6b 1
0 00d0 0 0 393837363534333231302f2e2d2c2b2a 1

/* tests/cache_bank_tb.sv */
`timescale 1ns/100ps

module cache_bank_tb;

  localparam cache_pkg::ret_id_t BANK_ID = 4'd5;
  localparam int MAX_RECORDS = 64;
  localparam int ACK_TIMEOUT = 200;
  localparam int DROP_TIMEOUT = 20;

  // Operation codes of the stimulus file
  localparam int OP_READ = 0;
  localparam int OP_WRITE = 1;
  localparam int OP_EXPECT_WB = 2;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  cache_pkg::cache_req_t req_data;
  logic                  ack;
  cache_pkg::cache_rsp_t rsp;
  logic                  fill_req;
  cache_pkg::mem_req_t   fill_msg;
  logic                  fill_ack;
  cache_pkg::line_t      fill_data;
  logic                  wb_req;
  cache_pkg::mem_req_t   wb_msg;
  logic                  wb_ack;

  // Six words per record: op, addr, data, mask, expect, flags
  logic [127:0] stim [0:MAX_RECORDS*6-1];
  logic [7:0]   mem_bytes [0:32767];
  logic [31:0]  lfsr;

  // Extract port traffic seen by the memory model
  cache_pkg::paddr_t wb_addr_q [$];
  cache_pkg::line_t  wb_line_q [$];

  // Address of the request in flight
  cache_pkg::paddr_t cur_addr;

  int fill_count;
  int wb_count;
  int errors;
  bit timed_out;

  cache_bank #(
    .NUM_WAYS(4),
    .BANK_ID(BANK_ID)
  ) uut (
    .clk(clk),
    .rst_n(rst_n),
    .req(req),
    .req_data(req_data),
    .ack(ack),
    .rsp(rsp),
    .fill_req(fill_req),
    .fill_msg(fill_msg),
    .fill_ack(fill_ack),
    .fill_data(fill_data),
    .wb_req(wb_req),
    .wb_msg(wb_msg),
    .wb_ack(wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // Memory ack delay of 0 to 3 cycles, one LFSR step per bit
  function automatic int random_delay();
    int d;
    d = 0;
    for (int i = 0; i < 2; i++) begin
      d = (d << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
    return d;
  endfunction

  function automatic string op_name(input logic [127:0] op);
    case (op)
      OP_READ: return "read";
      OP_WRITE: return "write";
      OP_EXPECT_WB: return "expect_wb";
      default: return "unknown";
    endcase
  endfunction

  function automatic cache_pkg::line_t read_line(input cache_pkg::paddr_t addr);
    cache_pkg::line_t line;
    for (int b = 0; b < 16; b++) begin
      line[b*8 +: 8] = mem_bytes[addr + b];
    end
    return line;
  endfunction

  // Low byte plus 5a, with the upper address bits folded in
  task automatic preload_memory();
    cache_pkg::paddr_t pa;
    for (int a = 0; a < 32768; a++) begin
      pa = cache_pkg::paddr_t'(a);
      mem_bytes[a] = (pa[7:0] + 8'h5a) ^ {1'b0, pa[14:8]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    errors++;
  endtask

  // Stops every wait loop so the run closes
  task automatic note_timeout(input string what);
    $display("timeout at %0t: no %s within the allowed cycles", $time, what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic check_mem_msg(input cache_pkg::mem_req_t msg, input logic write,
                               input string name);
    assert (msg.write == write) else report_mismatch({name, ".write"}, msg.write, write);
    assert (msg.addr[3:0] == 4'h0) else report_mismatch({name, ".addr"}, msg.addr, 0);
    assert (msg.size == 16'd16) else report_mismatch({name, ".size"}, msg.size, 16);
    assert (msg.ret_id == BANK_ID) else report_mismatch({name, ".ret_id"}, msg.ret_id, BANK_ID);
  endtask

  task automatic serve_fill();
    cache_pkg::mem_req_t msg;
    int delay;
    int waited;
    msg = fill_msg;
    check_mem_msg(msg, 1'b0, "fill_msg");
    // A fill always asks for the line of the request in flight
    assert (msg.addr == {cur_addr[14:4], 4'h0})
      else report_mismatch("fill_msg.addr", msg.addr, {cur_addr[14:4], 4'h0});
    delay = random_delay();
    repeat (delay) @(negedge clk);
    fill_data = read_line(msg.addr);
    fill_ack = 1'b1;
    fill_count++;
    waited = 0;
    while (fill_req && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > DROP_TIMEOUT) begin
        note_timeout("fill_req release");
      end
    end
    fill_ack = 1'b0;
  endtask

  task automatic serve_wb();
    cache_pkg::mem_req_t msg;
    int delay;
    int waited;
    msg = wb_msg;
    check_mem_msg(msg, 1'b1, "wb_msg");
    delay = random_delay();
    repeat (delay) @(negedge clk);
    for (int b = 0; b < 16; b++) begin
      mem_bytes[msg.addr + b] = msg.data[b*8 +: 8];
    end
    wb_addr_q.push_back(msg.addr);
    wb_line_q.push_back(msg.data);
    wb_ack = 1'b1;
    wb_count++;
    waited = 0;
    while (wb_req && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > DROP_TIMEOUT) begin
        note_timeout("wb_req release");
      end
    end
    wb_ack = 1'b0;
  endtask

  // Memory side of the fill and extract ports
  initial begin : memory_model
    forever begin
      @(negedge clk);
      if (rst_n && fill_req) begin
        serve_fill();
      end else if (rst_n && wb_req) begin
        serve_wb();
      end
    end
  end

  // Flags: bit 0 hit, bit 1 uncached response, bit 2 one fill
  task automatic run_request(input logic write, input cache_pkg::paddr_t addr,
                             input cache_pkg::line_t data, input cache_pkg::mask_t mask,
                             input cache_pkg::line_t exp_line, input logic [3:0] flags);
    int cycles;
    int fills_before;
    int wbs_before;
    fills_before = fill_count;
    wbs_before = wb_count;
    cur_addr = addr;
    req_data.write = write;
    req_data.addr = addr;
    req_data.data = data;
    req_data.mask = mask;
    req = 1'b1;
    cycles = 0;
    while (!ack && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) begin
        note_timeout("ack from the bank");
      end
    end
    if (!timed_out) begin
      assert (rsp.data == exp_line) else report_mismatch("rsp.data", rsp.data, exp_line);
      assert (rsp.uncached == flags[1])
        else report_mismatch("rsp.uncached", rsp.uncached, flags[1]);
      assert (fill_count - fills_before == int'(flags[2]))
        else report_mismatch("fill request count", fill_count - fills_before, flags[2]);
      if (flags[0]) begin
        // First negedge poll follows the sampling edge
        assert (cycles - 1 == 3) else report_mismatch("hit ack latency", cycles - 1, 3);
        assert (wb_count == wbs_before)
          else report_mismatch("wb request count", wb_count, wbs_before);
      end
    end
    req = 1'b0;
    cycles = 0;
    while (ack && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (cycles > DROP_TIMEOUT) begin
        note_timeout("ack release");
      end
    end
  endtask

  task automatic check_writeback(input cache_pkg::paddr_t addr, input cache_pkg::line_t exp_line);
    cache_pkg::paddr_t got_addr;
    cache_pkg::line_t  got_line;
    assert (wb_addr_q.size() > 0) else begin
      $display("missing writeback to %h on the extract port at %0t", addr, $time);
      errors++;
    end
    if (wb_addr_q.size() > 0) begin
      got_addr = wb_addr_q.pop_front();
      got_line = wb_line_q.pop_front();
      assert (got_addr == addr) else report_mismatch("wb_msg.addr", got_addr, addr);
      assert (got_line == exp_line) else report_mismatch("wb_msg.data", got_line, exp_line);
    end
  endtask

  initial begin : run_stimulus
    int                rec;
    int                errors_before;
    logic [127:0]      op;
    cache_pkg::paddr_t addr;
    rst_n = 1'b0;
    req = 1'b0;
    req_data = '0;
    fill_ack = 1'b0;
    fill_data = '0;
    wb_ack = 1'b0;
    lfsr = 32'h23fc_c16c;
    errors = 0;
    timed_out = 1'b0;
    cur_addr = '0;
    fill_count = 0;
    wb_count = 0;
    preload_memory();
    // Unused records stay all ones and end the list
    for (int i = 0; i < MAX_RECORDS*6; i++) begin
      stim[i] = '1;
    end
    $readmemh("tests/cache_bank_stimulus.txt", stim);
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    rec = 0;
    while (rec < MAX_RECORDS && !timed_out && stim[rec*6] != '1) begin
      op = stim[rec*6];
      addr = stim[rec*6+1][14:0];
      errors_before = errors;
      case (op)
        OP_READ: run_request(1'b0, addr, stim[rec*6+2], stim[rec*6+3][15:0],
                             stim[rec*6+4], stim[rec*6+5][3:0]);
        OP_WRITE: run_request(1'b1, addr, stim[rec*6+2], stim[rec*6+3][15:0],
                              stim[rec*6+4], stim[rec*6+5][3:0]);
        OP_EXPECT_WB: check_writeback(addr, stim[rec*6+4]);
        default: begin
          $display("record %0d holds an unknown operation code %0h", rec, op);
          errors++;
        end
      endcase
      $display("op %0d %s addr %h: %s", rec, op_name(op), addr,
               (errors == errors_before) ? "ok" : "FAILED");
      rec++;
    end
    assert (rec > 0) else begin
      $display("no operations were read from the stimulus file");
      errors++;
    end
    assert (wb_addr_q.size() == 0) else begin
      $display("%0d writebacks on the extract port were not expected", wb_addr_q.size());
      errors++;
    end
    $display("summary: %0d operations, %0d fills, %0d writebacks, %0d errors",
             rec, fill_count, wb_count, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
